/* tb.f */
rtl/issue_pkg.sv
rtl/issue_steer.sv
rtl/decode_exe.sv
rtl/alu_unit.sv
rtl/issue_exec_top.sv
bench/tb_clk.sv
bench/issue_exec_props.sv
bench/issue_exec_tb.sv

/* Bender.yml */
package:
  name: issue_exec

sources:
  - rtl/issue_pkg.sv
  - rtl/issue_steer.sv
  - rtl/decode_exe.sv
  - rtl/alu_unit.sv
  - rtl/issue_exec_top.sv
  - target: simulation
    files:
      - bench/tb_clk.sv
      - bench/issue_exec_props.sv
      - bench/issue_exec_tb.sv

/* bench/issue_exec_tb.sv */
// testbench for issue_exec_top. LFSR-driven slots and stalls are checked
// against a lane-queue model; run with the file list and issue_exec_tb as top.
`timescale 1ns/1ps

module issue_exec_tb import issue_pkg::*; ();

    localparam int N_SINGLE = 30;
    localparam int N_DUAL   = 30;
    localparam int N_MEM    = 40;
    localparam int N_FLUSH  = 40;
    localparam int N_BP     = 80;
    localparam int N_ORDER  = 60;
    localparam int N_MIX    = 400;
    localparam int CYCLE_LIMIT = N_SINGLE + N_DUAL + N_MEM + N_FLUSH + N_BP + N_ORDER
                               + N_MIX + 50;
    localparam int NONE = 3;

    typedef struct packed {
        logic        valid;
        logic        flush;
        logic [1:0]  cls;
        logic [2:0]  op;
        logic [63:0] op1;
        logic [63:0] op2;
        logic        rd_ena;
        logic [4:0]  rd_addr;
        logic [63:0] pc;
        logic [63:0] offset;
        logic [2:0]  sel;
        logic [31:0] stamp;
    } inst_t;

    logic        clk;
    logic        rst;
    logic        slot1_valid;
    logic        slot1_flush;
    logic        slot1_rd_ena;
    logic        slot2_valid;
    logic        slot2_flush;
    logic        slot2_rd_ena;
    inst_class_t slot1_class;
    inst_class_t slot2_class;
    alu_op_t     slot1_op;
    alu_op_t     slot2_op;
    logic [63:0] slot1_op1;
    logic [63:0] slot1_op2;
    logic [63:0] slot1_offset;
    logic [63:0] slot2_op1;
    logic [63:0] slot2_op2;
    logic [63:0] slot2_offset;
    reg_addr_t   slot1_rd_addr;
    reg_addr_t   slot2_rd_addr;
    pc_t         slot1_pc;
    pc_t         slot2_pc;
    mem_sel_t    slot1_sel;
    mem_sel_t    slot2_sel;
    logic        alu0_stall;
    logic        alu1_stall;
    logic        mem_stall;
    logic        accept1;
    logic        accept2;
    logic        alu0_valid;
    logic        alu0_rd_ena;
    logic        alu1_valid;
    logic        alu1_rd_ena;
    logic        mem_valid;
    logic        mem_rd_ena;
    logic [63:0] alu0_result;
    logic [63:0] alu1_result;
    logic [63:0] mem_base;
    logic [63:0] mem_store_data;
    logic [63:0] mem_offset;
    reg_addr_t   alu0_rd_addr;
    reg_addr_t   alu1_rd_addr;
    reg_addr_t   mem_rd_addr;
    pc_t         alu0_pc;
    pc_t         alu1_pc;
    pc_t         mem_pc;
    mem_sel_t    mem_sel;

    logic [15:0] lfsr;
    inst_t       s1;
    inst_t       s2;
    inst_t       q_alu0[$];
    inst_t       q_alu1[$];
    inst_t       q_mem[$];
    logic [2:0]  prev_st;
    logic [63:0] pc_next;
    int          cyc;
    int          cycles;
    int          errors;
    int          checks;
    int          ntests;
    int          w_valid;
    int          w_alu;
    int          w_mem;
    int          w_flush;
    int          w_stall;
    bit          slot2_on;

    tb_clk u_clk (.clk(clk));

    issue_exec_top #(.XLEN(64)) dut (.*);

    // galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1 steps once per bit.
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
            v[i] = b;
        end
        return v;
    endfunction

    function automatic logic [63:0] alu_expect(input logic [2:0] op, input logic [63:0] a,
                                               input logic [63:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[5:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic set_mix(input int v, input int a, input int m, input int f, input int s,
                           input bit two);
        w_valid = v;
        w_alu = a;
        w_mem = m;
        w_flush = f;
        w_stall = s;
        slot2_on = two;
    endtask

    task automatic new_inst(output inst_t i, input bit gen);
        logic [3:0] r;
        i = '0;
        if (gen) begin
            i.valid = take_bits(4) < w_valid;
            r = take_bits(4);
            if (r < w_alu) begin
                i.cls = CLASS_ALU;
            end else if (r < w_alu + w_mem) begin
                i.cls = CLASS_MEM;
            end else begin
                i.cls = r[0] ? CLASS_NOP : 2'd3;
            end
            i.flush = take_bits(4) < w_flush;
            i.op = take_bits(3);
            i.op1 = take_bits(64);
            i.op2 = take_bits(64);
            i.rd_ena = take_bits(1);
            i.rd_addr = take_bits(5);
            i.offset = take_bits(64);
            i.sel = take_bits(3);
            i.pc = pc_next;
            pc_next = pc_next + 64'd4;
        end
    endtask

    task automatic drive_slots();
        slot1_valid = s1.valid;
        slot1_flush = s1.flush;
        slot1_class = s1.cls;
        slot1_op = s1.op;
        slot1_op1 = s1.op1;
        slot1_op2 = s1.op2;
        slot1_rd_ena = s1.rd_ena;
        slot1_rd_addr = s1.rd_addr;
        slot1_pc = s1.pc;
        slot1_offset = s1.offset;
        slot1_sel = s1.sel;
        slot2_valid = s2.valid;
        slot2_flush = s2.flush;
        slot2_class = s2.cls;
        slot2_op = s2.op;
        slot2_op1 = s2.op1;
        slot2_op2 = s2.op2;
        slot2_rd_ena = s2.rd_ena;
        slot2_rd_addr = s2.rd_addr;
        slot2_pc = s2.pc;
        slot2_offset = s2.offset;
        slot2_sel = s2.sel;
    endtask

    task automatic check_alu_lane(input int k, input logic valid, input logic [63:0] result,
                                  input logic rd_ena, input logic [4:0] rd_addr,
                                  input logic [63:0] pc);
        inst_t e;
        string name;
        name = k ? "alu1" : "alu0";
        if (valid && !prev_st[k]) begin
            if ((k ? q_alu1.size() : q_alu0.size()) == 0) begin
                errors++;
                $display("%s produced a result that no accepted slot explains", name);
            end else begin
                e = k ? q_alu1.pop_front() : q_alu0.pop_front();
                check_value({name, "_result"}, result, alu_expect(e.op, e.op1, e.op2));
                check_value({name, "_rd_ena"}, rd_ena, e.rd_ena);
                check_value({name, "_rd_addr"}, rd_addr, e.rd_addr);
                check_value({name, "_pc"}, pc, e.pc);
                if (w_stall == 0) check_value({name, "_latency"}, cyc - e.stamp, 2);
            end
        end else if (!valid) begin
            check_value({name, "_rd_ena"}, rd_ena, 0);
        end
    endtask

    task automatic check_outputs();
        inst_t e;
        check_alu_lane(0, alu0_valid, alu0_result, alu0_rd_ena, alu0_rd_addr, alu0_pc);
        check_alu_lane(1, alu1_valid, alu1_result, alu1_rd_ena, alu1_rd_addr, alu1_pc);
        if (mem_valid && !prev_st[2]) begin
            if (q_mem.size() == 0) begin
                errors++;
                $display("mem lane went valid with no accepted memory slot");
            end else begin
                e = q_mem.pop_front();
                check_value("mem_pc", mem_pc, e.pc);
                check_value("mem_rd_ena", mem_rd_ena, e.rd_ena);
                check_value("mem_rd_addr", mem_rd_addr, e.rd_addr);
                check_value("mem_base", mem_base, e.op1);
                check_value("mem_store_data", mem_store_data, e.op2);
                check_value("mem_offset", mem_offset, e.offset);
                check_value("mem_sel", mem_sel, e.sel);
                if (w_stall == 0) check_value("mem_latency", cyc - e.stamp, 1);
            end
        end else if (!mem_valid) begin
            check_value("mem_rd_ena", mem_rd_ena, 0);
        end
    endtask

    task automatic push_lane(input int lane, input inst_t e);
        e.stamp = cyc;
        case (lane)
            0: q_alu0.push_back(e);
            1: q_alu1.push_back(e);
            2: q_mem.push_back(e);
            default: ;
        endcase
    endtask

    // checks the last edge, then drives new inputs and models the accepts.
    task automatic step(input bit gen);
        logic [2:0] st;
        logic a1;
        logic a2;
        int t1;
        int t2;
        @(negedge clk);
        check_outputs();
        st = '0;
        if (gen && w_stall > 0) begin
            st[0] = take_bits(4) < w_stall;
            st[1] = take_bits(4) < w_stall;
            st[2] = take_bits(4) < w_stall;
        end
        alu0_stall = st[0];
        alu1_stall = st[1];
        mem_stall = st[2];
        drive_slots();
        #1;
        t1 = NONE;
        t2 = NONE;
        if (s1.valid && !s1.flush && s1.cls == CLASS_ALU) t1 = 0;
        if (s1.valid && !s1.flush && s1.cls == CLASS_MEM) t1 = 2;
        if (s2.valid && !s2.flush && s2.cls == CLASS_ALU) t2 = (t1 == 0) ? 1 : 0;
        if (s2.valid && !s2.flush && s2.cls == CLASS_MEM) t2 = 2;
        a1 = (t1 == NONE) || !st[t1];
        a2 = (t2 == NONE) || (!st[t2] && !(t2 == 2 && t1 == 2));
        if (t1 != NONE && !a1) a2 = 1'b0;
        check_value("accept1", accept1, a1);
        check_value("accept2", accept2, a2);
        if (a1 && t1 != NONE) push_lane(t1, s1);
        if (a2 && t2 != NONE) push_lane(t2, s2);
        // a refused slot 2 moves up to slot 1 as decode would shift it.
        if (a1 && a2) begin
            new_inst(s1, gen);
            new_inst(s2, gen && slot2_on);
        end else if (a1) begin
            s1 = s2;
            new_inst(s2, gen && slot2_on);
        end
        prev_st = st;
        cyc++;
    endtask

    task automatic run_test(input string name, input int n);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        new_inst(s1, 1'b1);
        new_inst(s2, slot2_on);
        repeat (n) step(1'b1);
        while (s1.valid || s2.valid || q_alu0.size() > 0 || q_alu1.size() > 0
               || q_mem.size() > 0) begin
            step(1'b0);
        end
        ntests++;
        $display("test %-14s finished, %0d checks, %0d failures", name, checks - chk0,
                 errors - err0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        lfsr = 16'd25976;
        pc_next = 64'h1000;
        s1 = '0;
        s2 = '0;
        prev_st = '0;
        {cyc, cycles, errors, checks, ntests} = '0;
        set_mix(0, 0, 0, 0, 0, 1'b0);
        rst = 1'b1;
        alu0_stall = 1'b0;
        alu1_stall = 1'b0;
        mem_stall = 1'b0;
        drive_slots();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        set_mix(16, 16, 0, 0, 0, 1'b0);
        run_test("alu_single", N_SINGLE);
        set_mix(16, 16, 0, 0, 0, 1'b1);
        run_test("alu_dual", N_DUAL);
        set_mix(16, 0, 16, 0, 0, 1'b1);
        run_test("mem_issue", N_MEM);
        // every slot is flushed so no lane may fire.
        set_mix(16, 5, 5, 16, 0, 1'b1);
        run_test("flush_nop", N_FLUSH);
        set_mix(14, 10, 5, 2, 6, 1'b1);
        run_test("backpressure", N_BP);
        set_mix(16, 12, 4, 0, 9, 1'b1);
        run_test("order", N_ORDER);
        set_mix(12, 8, 5, 3, 4, 1'b1);
        run_test("random_mix", N_MIX);

        $display("summary: %0d tests, %0d checks, %0d failures, %0d assertion failures",
                 ntests, checks, errors, dut.u_props.fail_count);
        if (errors == 0 && dut.u_props.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* bench/issue_exec_props.sv */
// concurrent checks on the issue stage that bind to the top level.
// covers reset state, hold under stall and the slot order rule.
`timescale 1ns/1ps

module issue_exec_props (
    input logic        clk,
    input logic        rst,
    input logic        alu0_valid,
    input logic        alu1_valid,
    input logic        mem_valid,
    input logic        alu0_stall,
    input logic        alu1_stall,
    input logic        mem_stall,
    input logic [63:0] alu0_result,
    input logic [63:0] alu1_result,
    input logic [63:0] alu0_pc,
    input logic [63:0] alu1_pc,
    input logic [63:0] mem_pc,
    input logic [63:0] mem_base,
    input logic        accept1,
    input logic        accept2,
    input logic        slot1_valid,
    input logic        slot1_flush
);

    // number of failed properties.
    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk)
        rst |=> !(alu0_valid || alu1_valid || mem_valid))
        else begin
            $error("a lane output is valid right after reset");
            fail_count++;
        end

    alu0_hold: assert property (@(posedge clk) disable iff (rst)
        (alu0_valid && alu0_stall) |=> $stable({alu0_valid, alu0_result, alu0_pc}))
        else begin
            $error("alu0 output changed while stalled");
            fail_count++;
        end

    alu1_hold: assert property (@(posedge clk) disable iff (rst)
        (alu1_valid && alu1_stall) |=> $stable({alu1_valid, alu1_result, alu1_pc}))
        else begin
            $error("alu1 output changed while stalled");
            fail_count++;
        end

    mem_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && mem_stall) |=> $stable({mem_valid, mem_pc, mem_base}))
        else begin
            $error("mem output changed while stalled");
            fail_count++;
        end

    // slot 2 never overtakes a live, refused slot 1.
    slot_order: assert property (@(posedge clk) disable iff (rst)
        accept2 |-> (accept1 || !slot1_valid || slot1_flush))
        else begin
            $error("slot 2 accepted while slot 1 was held back");
            fail_count++;
        end

endmodule

bind issue_exec_top issue_exec_props u_props (.*);

/* bench/tb_clk.sv */
// free-running testbench clock, 40 ns period.
// starts low at time zero.
`timescale 1ns/1ps

module tb_clk #(
    parameter real PERIOD = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

/* rtl/issue_exec_top.sv */
// issue and execute top. steering picks lanes, the lane registers capture
// the slots, and two ALUs produce results; the memory lane leaves as is.
`timescale 1ns/1ps

module issue_exec_top import issue_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            slot1_valid,
    input  logic            slot1_flush,
    input  inst_class_t     slot1_class,
    input  alu_op_t         slot1_op,
    input  logic [XLEN-1:0] slot1_op1,
    input  logic [XLEN-1:0] slot1_op2,
    input  logic            slot1_rd_ena,
    input  reg_addr_t       slot1_rd_addr,
    input  pc_t             slot1_pc,
    input  logic [XLEN-1:0] slot1_offset,
    input  mem_sel_t        slot1_sel,
    input  logic            slot2_valid,
    input  logic            slot2_flush,
    input  inst_class_t     slot2_class,
    input  alu_op_t         slot2_op,
    input  logic [XLEN-1:0] slot2_op1,
    input  logic [XLEN-1:0] slot2_op2,
    input  logic            slot2_rd_ena,
    input  reg_addr_t       slot2_rd_addr,
    input  pc_t             slot2_pc,
    input  logic [XLEN-1:0] slot2_offset,
    input  mem_sel_t        slot2_sel,
    input  logic            alu0_stall,
    input  logic            alu1_stall,
    input  logic            mem_stall,
    output logic            accept1,
    output logic            accept2,
    output logic            alu0_valid,
    output logic [XLEN-1:0] alu0_result,
    output logic            alu0_rd_ena,
    output reg_addr_t       alu0_rd_addr,
    output pc_t             alu0_pc,
    output logic            alu1_valid,
    output logic [XLEN-1:0] alu1_result,
    output logic            alu1_rd_ena,
    output reg_addr_t       alu1_rd_addr,
    output pc_t             alu1_pc,
    output logic            mem_valid,
    output pc_t             mem_pc,
    output logic            mem_rd_ena,
    output reg_addr_t       mem_rd_addr,
    output logic [XLEN-1:0] mem_base,
    output logic [XLEN-1:0] mem_store_data,
    output logic [XLEN-1:0] mem_offset,
    output mem_sel_t        mem_sel
);

    lane_sel_t       alu0_sel;
    lane_sel_t       alu1_sel;
    lane_sel_t       mem_sel_lane;
    logic            alu0_valid_q;
    alu_op_t         alu0_op_q;
    logic [XLEN-1:0] alu0_op1_q;
    logic [XLEN-1:0] alu0_op2_q;
    logic            alu0_rd_ena_q;
    reg_addr_t       alu0_rd_addr_q;
    pc_t             alu0_pc_q;
    logic            alu1_valid_q;
    alu_op_t         alu1_op_q;
    logic [XLEN-1:0] alu1_op1_q;
    logic [XLEN-1:0] alu1_op2_q;
    logic            alu1_rd_ena_q;
    reg_addr_t       alu1_rd_addr_q;
    pc_t             alu1_pc_q;

    issue_steer u_steer (.*);

    decode_exe #(.XLEN(XLEN)) u_decode_exe (.*);

    alu_unit #(.XLEN(XLEN)) alu0 (
        .clk         (clk),
        .rst         (rst),
        .stall       (alu0_stall),
        .in_valid    (alu0_valid_q),
        .in_op       (alu0_op_q),
        .in_op1      (alu0_op1_q),
        .in_op2      (alu0_op2_q),
        .in_rd_ena   (alu0_rd_ena_q),
        .in_rd_addr  (alu0_rd_addr_q),
        .in_pc       (alu0_pc_q),
        .out_valid   (alu0_valid),
        .out_result  (alu0_result),
        .out_rd_ena  (alu0_rd_ena),
        .out_rd_addr (alu0_rd_addr),
        .out_pc      (alu0_pc)
    );

    alu_unit #(.XLEN(XLEN)) alu1 (
        .clk         (clk),
        .rst         (rst),
        .stall       (alu1_stall),
        .in_valid    (alu1_valid_q),
        .in_op       (alu1_op_q),
        .in_op1      (alu1_op1_q),
        .in_op2      (alu1_op2_q),
        .in_rd_ena   (alu1_rd_ena_q),
        .in_rd_addr  (alu1_rd_addr_q),
        .in_pc       (alu1_pc_q),
        .out_valid   (alu1_valid),
        .out_result  (alu1_result),
        .out_rd_ena  (alu1_rd_ena),
        .out_rd_addr (alu1_rd_addr),
        .out_pc      (alu1_pc)
    );

endmodule

/* rtl/alu_unit.sv */
// registered integer ALU for one execution lane. the result and its tags
// are captured one cycle after the lane register and held while stalled.
`timescale 1ns/1ps

module alu_unit import issue_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            in_valid,
    input  alu_op_t         in_op,
    input  logic [XLEN-1:0] in_op1,
    input  logic [XLEN-1:0] in_op2,
    input  logic            in_rd_ena,
    input  reg_addr_t       in_rd_addr,
    input  pc_t             in_pc,
    output logic            out_valid,
    output logic [XLEN-1:0] out_result,
    output logic            out_rd_ena,
    output reg_addr_t       out_rd_addr,
    output pc_t             out_pc
);

    logic [XLEN-1:0] result;
    logic            less;

    assign less = $signed(in_op1) < $signed(in_op2);

    always_comb begin
        case (in_op)
            ALU_ADD:  result = in_op1 + in_op2;
            ALU_SUB:  result = in_op1 - in_op2;
            ALU_AND:  result = in_op1 & in_op2;
            ALU_OR:   result = in_op1 | in_op2;
            ALU_XOR:  result = in_op1 ^ in_op2;
            ALU_SLL:  result = in_op1 << in_op2[5:0];
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, less};
            default:  result = in_op2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            out_rd_ena <= 1'b0;
        end else if (!stall) begin
            out_valid  <= in_valid;
            out_rd_ena <= in_valid & in_rd_ena;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_result  <= result;
            out_rd_addr <= in_rd_addr;
            out_pc      <= in_pc;
        end
    end

endmodule

/* rtl/decode_exe.sv */
// decode to execute lane registers for alu0, alu1 and the memory lane.
// each lane loads slot 1 or slot 2, holds, or takes a bubble per its select.
`timescale 1ns/1ps

module decode_exe import issue_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst,
    input  lane_sel_t       alu0_sel,
    input  lane_sel_t       alu1_sel,
    input  lane_sel_t       mem_sel_lane,
    input  alu_op_t         slot1_op,
    input  logic [XLEN-1:0] slot1_op1,
    input  logic [XLEN-1:0] slot1_op2,
    input  logic            slot1_rd_ena,
    input  reg_addr_t       slot1_rd_addr,
    input  pc_t             slot1_pc,
    input  logic [XLEN-1:0] slot1_offset,
    input  mem_sel_t        slot1_sel,
    input  alu_op_t         slot2_op,
    input  logic [XLEN-1:0] slot2_op1,
    input  logic [XLEN-1:0] slot2_op2,
    input  logic            slot2_rd_ena,
    input  reg_addr_t       slot2_rd_addr,
    input  pc_t             slot2_pc,
    input  logic [XLEN-1:0] slot2_offset,
    input  mem_sel_t        slot2_sel,
    output logic            alu0_valid_q,
    output alu_op_t         alu0_op_q,
    output logic [XLEN-1:0] alu0_op1_q,
    output logic [XLEN-1:0] alu0_op2_q,
    output logic            alu0_rd_ena_q,
    output reg_addr_t       alu0_rd_addr_q,
    output pc_t             alu0_pc_q,
    output logic            alu1_valid_q,
    output alu_op_t         alu1_op_q,
    output logic [XLEN-1:0] alu1_op1_q,
    output logic [XLEN-1:0] alu1_op2_q,
    output logic            alu1_rd_ena_q,
    output reg_addr_t       alu1_rd_addr_q,
    output pc_t             alu1_pc_q,
    output logic            mem_valid,
    output pc_t             mem_pc,
    output logic            mem_rd_ena,
    output reg_addr_t       mem_rd_addr,
    output logic [XLEN-1:0] mem_base,
    output logic [XLEN-1:0] mem_store_data,
    output logic [XLEN-1:0] mem_offset,
    output mem_sel_t        mem_sel
);

    lane_sel_t       alu_sel [2];
    logic            lane_valid [2];
    alu_op_t         lane_op [2];
    logic [XLEN-1:0] lane_op1 [2];
    logic [XLEN-1:0] lane_op2 [2];
    logic            lane_rd_ena [2];
    reg_addr_t       lane_rd_addr [2];
    pc_t             lane_pc [2];

    assign alu_sel[0] = alu0_sel;
    assign alu_sel[1] = alu1_sel;

    for (genvar k = 0; k < 2; k++) begin : g_alu_lane
        always_ff @(posedge clk) begin
            if (rst) begin
                lane_valid[k]  <= 1'b0;
                lane_rd_ena[k] <= 1'b0;
            end else begin
                case (alu_sel[k])
                    LANE_SLOT1: begin
                        lane_valid[k]  <= 1'b1;
                        lane_rd_ena[k] <= slot1_rd_ena;
                    end
                    LANE_SLOT2: begin
                        lane_valid[k]  <= 1'b1;
                        lane_rd_ena[k] <= slot2_rd_ena;
                    end
                    LANE_IDLE: begin
                        lane_valid[k]  <= 1'b0;
                        lane_rd_ena[k] <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end

        // payload only moves on a load.
        always_ff @(posedge clk) begin
            if (alu_sel[k] == LANE_SLOT1) begin
                lane_op[k]      <= slot1_op;
                lane_op1[k]     <= slot1_op1;
                lane_op2[k]     <= slot1_op2;
                lane_rd_addr[k] <= slot1_rd_addr;
                lane_pc[k]      <= slot1_pc;
            end else if (alu_sel[k] == LANE_SLOT2) begin
                lane_op[k]      <= slot2_op;
                lane_op1[k]     <= slot2_op1;
                lane_op2[k]     <= slot2_op2;
                lane_rd_addr[k] <= slot2_rd_addr;
                lane_pc[k]      <= slot2_pc;
            end
        end
    end

    assign alu0_valid_q   = lane_valid[0];
    assign alu0_op_q      = lane_op[0];
    assign alu0_op1_q     = lane_op1[0];
    assign alu0_op2_q     = lane_op2[0];
    assign alu0_rd_ena_q  = lane_rd_ena[0];
    assign alu0_rd_addr_q = lane_rd_addr[0];
    assign alu0_pc_q      = lane_pc[0];
    assign alu1_valid_q   = lane_valid[1];
    assign alu1_op_q      = lane_op[1];
    assign alu1_op1_q     = lane_op1[1];
    assign alu1_op2_q     = lane_op2[1];
    assign alu1_rd_ena_q  = lane_rd_ena[1];
    assign alu1_rd_addr_q = lane_rd_addr[1];
    assign alu1_pc_q      = lane_pc[1];

    // memory lane, base comes from op1 and store data from op2.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid  <= 1'b0;
            mem_rd_ena <= 1'b0;
        end else begin
            case (mem_sel_lane)
                LANE_SLOT1: begin
                    mem_valid  <= 1'b1;
                    mem_rd_ena <= slot1_rd_ena;
                end
                LANE_SLOT2: begin
                    mem_valid  <= 1'b1;
                    mem_rd_ena <= slot2_rd_ena;
                end
                LANE_IDLE: begin
                    mem_valid  <= 1'b0;
                    mem_rd_ena <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_sel_lane == LANE_SLOT1) begin
            mem_pc         <= slot1_pc;
            mem_rd_addr    <= slot1_rd_addr;
            mem_base       <= slot1_op1;
            mem_store_data <= slot1_op2;
            mem_offset     <= slot1_offset;
            mem_sel        <= slot1_sel;
        end else if (mem_sel_lane == LANE_SLOT2) begin
            mem_pc         <= slot2_pc;
            mem_rd_addr    <= slot2_rd_addr;
            mem_base       <= slot2_op1;
            mem_store_data <= slot2_op2;
            mem_offset     <= slot2_offset;
            mem_sel        <= slot2_sel;
        end
    end

endmodule

/* rtl/issue_steer.sv */
// lane steering for the two decode slots. purely combinational: picks a lane
// per slot, returns the per-slot accept and drives the lane-register selects.
`timescale 1ns/1ps

module issue_steer import issue_pkg::*; (
    input  logic        slot1_valid,
    input  logic        slot1_flush,
    input  inst_class_t slot1_class,
    input  logic        slot2_valid,
    input  logic        slot2_flush,
    input  inst_class_t slot2_class,
    input  logic        alu0_stall,
    input  logic        alu1_stall,
    input  logic        mem_stall,
    output logic        accept1,
    output logic        accept2,
    output lane_sel_t   alu0_sel,
    output lane_sel_t   alu1_sel,
    output lane_sel_t   mem_sel_lane
);

    logic s1_live;
    logic s2_live;
    logic s1_alu;
    logic s1_mem;
    logic s2_alu;
    logic s2_mem;
    logic s2_block;

    // a flushed slot is live for nothing.
    assign s1_live = slot1_valid & ~slot1_flush;
    assign s2_live = slot2_valid & ~slot2_flush;

    assign s1_alu = s1_live & (slot1_class == CLASS_ALU);
    assign s1_mem = s1_live & (slot1_class == CLASS_MEM);
    assign s2_alu = s2_live & (slot2_class == CLASS_ALU);
    assign s2_mem = s2_live & (slot2_class == CLASS_MEM);

    assign accept1 = ~((s1_alu & alu0_stall) | (s1_mem & mem_stall));

    // slot 2 alu goes to alu1 only behind a slot 1 alu.
    // refusing slot 1 also refuses slot 2 to keep program order.
    assign s2_block = (s2_alu & (s1_alu ? alu1_stall : alu0_stall))
                    | (s2_mem & (s1_mem | mem_stall))
                    | (s1_live & ~accept1);

    assign accept2 = ~s2_block;

    always_comb begin
        if (alu0_stall) begin
            alu0_sel = LANE_HOLD;
        end else if (s1_alu && accept1) begin
            alu0_sel = LANE_SLOT1;
        end else if (s2_alu && !s1_alu && accept2) begin
            alu0_sel = LANE_SLOT2;
        end else begin
            alu0_sel = LANE_IDLE;
        end
    end

    always_comb begin
        if (alu1_stall) begin
            alu1_sel = LANE_HOLD;
        end else if (s2_alu && s1_alu && accept2) begin
            alu1_sel = LANE_SLOT2;
        end else begin
            alu1_sel = LANE_IDLE;
        end
    end

    always_comb begin
        if (mem_stall) begin
            mem_sel_lane = LANE_HOLD;
        end else if (s1_mem && accept1) begin
            mem_sel_lane = LANE_SLOT1;
        end else if (s2_mem && accept2) begin
            mem_sel_lane = LANE_SLOT2;
        end else begin
            mem_sel_lane = LANE_IDLE;
        end
    end

endmodule

/* rtl/issue_pkg.sv */
// shared widths, instruction classes, ALU operations and lane-select codes
// for the dual-issue stage. every module imports this package in its header.
package issue_pkg;

    // operand width default; modules take XLEN as a parameter.
    parameter int XLEN_DEFAULT = 64;

    typedef logic [XLEN_DEFAULT-1:0] xlen_t;
    typedef logic [63:0]             pc_t;
    typedef logic [4:0]              reg_addr_t;
    typedef logic [1:0]              inst_class_t;
    typedef logic [2:0]              alu_op_t;
    typedef logic [2:0]              mem_sel_t;
    typedef logic [1:0]              lane_sel_t;

    // instruction class, code 3 is treated like a nop.
    localparam inst_class_t CLASS_NOP = 2'd0;
    localparam inst_class_t CLASS_ALU = 2'd1;
    localparam inst_class_t CLASS_MEM = 2'd2;

    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_XOR  = 3'd4;
    localparam alu_op_t ALU_SLL  = 3'd5;
    localparam alu_op_t ALU_SLT  = 3'd6;
    localparam alu_op_t ALU_PASS = 3'd7;

    // what a lane register does in a cycle.
    localparam lane_sel_t LANE_IDLE  = 2'd0;
    localparam lane_sel_t LANE_SLOT1 = 2'd1;
    localparam lane_sel_t LANE_SLOT2 = 2'd2;
    localparam lane_sel_t LANE_HOLD  = 2'd3;

endpackage
